// ==== design/mshr_pkg.sv ====
// Shared widths, types and helpers for the MSHR unit.
// Modules import this package inside their bodies and use scoped
// names in their port lists.

package mshr_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int ADDR_W   = 32;
    localparam int BLOCK_W  = 64;
    localparam int TAG_W    = 4;
    // Byte offset bits within one 8-byte block
    localparam int OFFSET_W = 3;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // ========================================
    // Encodings
    // ========================================
    typedef enum logic {
        CMD_LOAD,
        CMD_STORE
    } cmd_e;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD,
        SIZE_DOUBLE
    } size_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_DEP,
        ST_RD_MEM,
        ST_WAIT_MEM,
        ST_FILL
    } entry_state_e;

    // ========================================
    // Bundles
    // ========================================
    // Store data is right-aligned in the block
    typedef struct packed {
        cmd_e   cmd;
        addr_t  addr;
        size_e  size;
        block_t data;
    } miss_req_t;

    typedef struct packed {
        logic      fire;
        miss_req_t req;
        logic      dep;
        tag_t      dep_idx;
    } dispatch_t;

    typedef struct packed {
        logic  busy;
        logic  linked;
        addr_t blk_addr;
    } entry_status_t;

    typedef struct packed {
        addr_t addr;
        tag_t  tag;
    } mem_req_t;

    typedef struct packed {
        tag_t   tag;
        block_t data;
    } mem_rsp_t;

    typedef struct packed {
        cmd_e   cmd;
        addr_t  addr;
        block_t data;
        tag_t   idx;
    } fill_t;

    // Clear the byte offset to get the block-aligned address
    function automatic addr_t block_base(input addr_t addr);
        return {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    endfunction

    // Write store data into a block at its byte offset, aligned sizes only
    function automatic block_t merge_store(input block_t base, input block_t data,
                                           input addr_t addr, input size_e size);
        block_t     mask;
        logic [5:0] shamt;
        shamt = {addr[OFFSET_W-1:0], 3'b000};
        case (size)
            SIZE_BYTE: mask = block_t'(64'h0000_0000_0000_00ff);
            SIZE_HALF: mask = block_t'(64'h0000_0000_0000_ffff);
            SIZE_WORD: mask = block_t'(64'h0000_0000_ffff_ffff);
            default:   mask = '1;
        endcase
        mask = mask << shamt;
        return (base & ~mask) | ((data << shamt) & mask);
    endfunction

endpackage

// ==== design/mshr_alloc.sv ====
// Request allocator for the MSHR unit.
// Picks the lowest idle entry for each incoming miss and looks up an
// open miss to the same block that the new entry should link behind.

`timescale 1ns/1ps

module mshr_alloc #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic                                    req_valid_i,
    input  mshr_pkg::miss_req_t                     req_i,
    input  mshr_pkg::entry_status_t [NUM_ENTRIES-1:0] status_i,
    output logic                                    req_ready_o,
    output mshr_pkg::dispatch_t                     dispatch_o,
    output logic [NUM_ENTRIES-1:0]                  alloc_sel_o
);
    import mshr_pkg::*;

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic             free_found;
    logic [IDX_W-1:0] free_idx;
    logic             dep_found;
    tag_t             dep_idx;
    addr_t            req_blk;
    logic             fire;

    assign req_blk = block_base(req_i.addr);

    // ========================================
    // Lowest idle entry
    // ========================================
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!status_i[i].busy && !free_found) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    // ========================================
    // Same-block lookup
    // ========================================
    // Only the youngest open miss of a chain is unlinked, so at most one hits
    always_comb begin
        dep_found = 1'b0;
        dep_idx   = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (status_i[i].busy && !status_i[i].linked
                && (status_i[i].blk_addr == req_blk)) begin
                dep_found = 1'b1;
                dep_idx   = tag_t'(i);
            end
        end
    end

    assign req_ready_o = free_found;
    assign fire        = req_valid_i && free_found;

    always_comb begin
        dispatch_o.fire    = fire;
        dispatch_o.req     = req_i;
        dispatch_o.dep     = dep_found;
        dispatch_o.dep_idx = dep_idx;
    end

    // One-hot select, high only on a transfer
    always_comb begin
        alloc_sel_o = '0;
        if (fire) begin
            alloc_sel_o[free_idx] = 1'b1;
        end
    end

endmodule

// ==== design/mshr_entry.sv ====
// One MSHR entry: holds a single outstanding miss until its fill is taken.
// The block comes either from memory or from the completion of the older
// entry it is linked behind; store data is merged in before the fill.

`timescale 1ns/1ps

module mshr_entry #(
    parameter int NUM_ENTRIES = 4,
    parameter int ENTRY_IDX   = 0
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    // From the allocator
    input  mshr_pkg::dispatch_t                 dispatch_i,
    input  logic                                alloc_sel_i,
    // Completion bus from all entries
    input  logic [NUM_ENTRIES-1:0]              cp_flag_i,
    input  mshr_pkg::block_t [NUM_ENTRIES-1:0]  cp_block_i,
    // Memory side
    input  logic                                mem_gnt_i,
    input  logic                                mem_rsp_valid_i,
    input  mshr_pkg::mem_rsp_t                  mem_rsp_i,
    input  logic                                fill_gnt_i,
    // Status and completion of this entry
    output mshr_pkg::entry_status_t             status_o,
    output logic                                cp_flag_o,
    output mshr_pkg::block_t                    cp_block_o,
    // Requests towards the drain
    output logic                                mem_req_valid_o,
    output mshr_pkg::mem_req_t                  mem_req_o,
    output logic                                fill_valid_o,
    output mshr_pkg::fill_t                     fill_o
);
    import mshr_pkg::*;

    localparam int   IDX_W  = $clog2(NUM_ENTRIES);
    localparam tag_t MY_TAG = tag_t'(ENTRY_IDX);

    // ========================================
    // Entry storage
    // ========================================
    entry_state_e     state_q;
    logic             linked_q;
    miss_req_t        req_q;
    block_t           blk_q;
    logic [IDX_W-1:0] link_idx_q;

    logic   dep_done;
    logic   rsp_hit;
    logic   linking;
    logic   fill_done;
    block_t base_blk;
    block_t merged_blk;

    // Predecessor finished, or memory returned our tag
    assign dep_done  = (state_q == ST_WAIT_DEP) && cp_flag_i[link_idx_q];
    assign rsp_hit   = (state_q == ST_WAIT_MEM) && mem_rsp_valid_i
                       && (mem_rsp_i.tag == MY_TAG);
    assign fill_done = (state_q == ST_FILL) && fill_gnt_i;

    // A younger miss to our block links behind us
    assign linking = dispatch_i.fire && dispatch_i.dep && (dispatch_i.dep_idx == MY_TAG);

    assign base_blk   = (state_q == ST_WAIT_DEP) ? cp_block_i[link_idx_q] : mem_rsp_i.data;
    assign merged_blk = (req_q.cmd == CMD_STORE)
                        ? merge_store(base_blk, req_q.data, req_q.addr, req_q.size)
                        : base_blk;

    // ========================================
    // FSM
    // ========================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            linked_q  <= 1'b0;
            cp_flag_o <= 1'b0;
        end else begin
            cp_flag_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (alloc_sel_i) begin
                        state_q <= dispatch_i.dep ? ST_WAIT_DEP : ST_RD_MEM;
                    end
                end
                ST_WAIT_DEP: begin
                    if (dep_done) begin
                        state_q <= ST_FILL;
                    end
                end
                ST_RD_MEM: begin
                    if (mem_gnt_i) begin
                        state_q <= ST_WAIT_MEM;
                    end
                end
                ST_WAIT_MEM: begin
                    if (rsp_hit) begin
                        state_q <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (fill_gnt_i) begin
                        state_q   <= ST_IDLE;
                        cp_flag_o <= 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase

            // Going idle wins over a link in the same cycle
            if (fill_done) begin
                linked_q <= 1'b0;
            end else if (linking) begin
                linked_q <= 1'b1;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if ((state_q == ST_IDLE) && alloc_sel_i) begin
            req_q      <= dispatch_i.req;
            link_idx_q <= dispatch_i.dep_idx[IDX_W-1:0];
        end
        if (dep_done || rsp_hit) begin
            blk_q <= merged_blk;
        end
        if (fill_done) begin
            cp_block_o <= blk_q;
        end
    end

    // ========================================
    // Outputs
    // ========================================
    always_comb begin
        status_o.busy     = (state_q != ST_IDLE);
        status_o.linked   = linked_q;
        status_o.blk_addr = block_base(req_q.addr);
    end

    assign mem_req_valid_o = (state_q == ST_RD_MEM);

    always_comb begin
        mem_req_o.addr = block_base(req_q.addr);
        mem_req_o.tag  = MY_TAG;
    end

    assign fill_valid_o = (state_q == ST_FILL);

    always_comb begin
        fill_o.cmd  = req_q.cmd;
        fill_o.addr = req_q.addr;
        fill_o.data = blk_q;
        fill_o.idx  = MY_TAG;
    end

endmodule

// ==== design/mshr_drain.sv ====
// Drains the entries onto the memory request port and the fill port.
// Each port has its own round-robin pointer; a stalled winner is locked
// so valid and payload stay put until the port accepts.

`timescale 1ns/1ps

module mshr_drain #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    // Per-entry requests
    input  logic [NUM_ENTRIES-1:0]                  ent_mem_req_valid_i,
    input  mshr_pkg::mem_req_t [NUM_ENTRIES-1:0]    ent_mem_req_i,
    input  logic [NUM_ENTRIES-1:0]                  ent_fill_valid_i,
    input  mshr_pkg::fill_t [NUM_ENTRIES-1:0]       ent_fill_i,
    // Port back-pressure
    input  logic                                    mem_req_ready_i,
    input  logic                                    fill_ready_i,
    // Grants back to the entries
    output logic [NUM_ENTRIES-1:0]                  mem_gnt_o,
    output logic [NUM_ENTRIES-1:0]                  fill_gnt_o,
    // Top-level ports
    output logic                                    mem_req_valid_o,
    output mshr_pkg::mem_req_t                      mem_req_o,
    output logic                                    fill_valid_o,
    output mshr_pkg::fill_t                         fill_o
);
    import mshr_pkg::*;

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    // Port 0 is the memory request port, port 1 the fill port
    logic [NUM_ENTRIES-1:0] req_vec    [2];
    logic                   port_ready [2];
    logic [IDX_W-1:0]       sel        [2];
    logic                   port_fire  [2];
    logic [NUM_ENTRIES-1:0] gnt        [2];

    // First raised request at or after the pointer
    function automatic logic [IDX_W-1:0] rr_pick(input logic [NUM_ENTRIES-1:0] vec,
                                                 input logic [IDX_W-1:0] start);
        logic [IDX_W-1:0] pick;
        logic             found;
        int               idx;
        pick  = start;
        found = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            idx = (int'(start) + i) % NUM_ENTRIES;
            if (vec[idx] && !found) begin
                pick  = IDX_W'(idx);
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    assign req_vec[0]    = ent_mem_req_valid_i;
    assign req_vec[1]    = ent_fill_valid_i;
    assign port_ready[0] = mem_req_ready_i;
    assign port_ready[1] = fill_ready_i;

    // ========================================
    // Round-robin arbiters
    // ========================================
    for (genvar p = 0; p < 2; p++) begin : g_port
        logic [IDX_W-1:0] ptr_q;
        logic [IDX_W-1:0] lock_idx_q;
        logic             lock_q;

        assign sel[p]       = lock_q ? lock_idx_q : rr_pick(req_vec[p], ptr_q);
        assign port_fire[p] = (|req_vec[p]) && port_ready[p];
        assign gnt[p]       = port_fire[p] ? (NUM_ENTRIES'(1) << sel[p]) : '0;

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                ptr_q      <= '0;
                lock_q     <= 1'b0;
                lock_idx_q <= '0;
            end else begin
                // Hold the winner while the port stalls
                lock_q     <= (|req_vec[p]) && !port_ready[p];
                lock_idx_q <= sel[p];
                if (port_fire[p]) begin
                    ptr_q <= (sel[p] == IDX_W'(NUM_ENTRIES - 1)) ? '0 : sel[p] + 1'b1;
                end
            end
        end
    end

    assign mem_gnt_o  = gnt[0];
    assign fill_gnt_o = gnt[1];

    assign mem_req_valid_o = |ent_mem_req_valid_i;
    assign mem_req_o       = ent_mem_req_i[sel[0]];
    assign fill_valid_o    = |ent_fill_valid_i;
    assign fill_o          = ent_fill_i[sel[1]];

endmodule

// ==== design/mshr_unit.sv ====
// Top level of the MSHR unit for a write-allocate data cache.
// Misses enter on the request port, block reads leave on the memory
// port, and completed blocks leave on the fill port.

`timescale 1ns/1ps

module mshr_unit #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic                clk_i,
    input  logic                rst_i,
    // Miss requests
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  mshr_pkg::miss_req_t req_i,
    // Block reads to memory
    output logic                mem_req_valid_o,
    input  logic                mem_req_ready_i,
    output mshr_pkg::mem_req_t  mem_req_o,
    // Tagged memory responses
    input  logic                mem_rsp_valid_i,
    input  mshr_pkg::mem_rsp_t  mem_rsp_i,
    // Completed misses
    output logic                fill_valid_o,
    input  logic                fill_ready_i,
    output mshr_pkg::fill_t     fill_o
);
    import mshr_pkg::*;

    // ========================================
    // Internal wiring
    // ========================================
    entry_status_t [NUM_ENTRIES-1:0] status;
    dispatch_t                       dispatch;
    logic [NUM_ENTRIES-1:0]          alloc_sel;
    logic [NUM_ENTRIES-1:0]          cp_flag;
    block_t [NUM_ENTRIES-1:0]        cp_block;
    logic [NUM_ENTRIES-1:0]          ent_mem_req_valid;
    mem_req_t [NUM_ENTRIES-1:0]      ent_mem_req;
    logic [NUM_ENTRIES-1:0]          mem_gnt;
    logic [NUM_ENTRIES-1:0]          ent_fill_valid;
    fill_t [NUM_ENTRIES-1:0]         ent_fill;
    logic [NUM_ENTRIES-1:0]          fill_gnt;

    mshr_alloc #(.NUM_ENTRIES(NUM_ENTRIES)) u_alloc (
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .status_i    (status),
        .req_ready_o (req_ready_o),
        .dispatch_o  (dispatch),
        .alloc_sel_o (alloc_sel)
    );

    for (genvar g = 0; g < NUM_ENTRIES; g++) begin : g_entry
        mshr_entry #(
            .NUM_ENTRIES (NUM_ENTRIES),
            .ENTRY_IDX   (g)
        ) u_entry (
            .clk_i           (clk_i),
            .rst_i           (rst_i),
            .dispatch_i      (dispatch),
            .alloc_sel_i     (alloc_sel[g]),
            .cp_flag_i       (cp_flag),
            .cp_block_i      (cp_block),
            .mem_gnt_i       (mem_gnt[g]),
            .mem_rsp_valid_i (mem_rsp_valid_i),
            .mem_rsp_i       (mem_rsp_i),
            .fill_gnt_i      (fill_gnt[g]),
            .status_o        (status[g]),
            .cp_flag_o       (cp_flag[g]),
            .cp_block_o      (cp_block[g]),
            .mem_req_valid_o (ent_mem_req_valid[g]),
            .mem_req_o       (ent_mem_req[g]),
            .fill_valid_o    (ent_fill_valid[g]),
            .fill_o          (ent_fill[g])
        );
    end

    mshr_drain #(.NUM_ENTRIES(NUM_ENTRIES)) u_drain (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .ent_mem_req_valid_i (ent_mem_req_valid),
        .ent_mem_req_i       (ent_mem_req),
        .ent_fill_valid_i    (ent_fill_valid),
        .ent_fill_i          (ent_fill),
        .mem_req_ready_i     (mem_req_ready_i),
        .fill_ready_i        (fill_ready_i),
        .mem_gnt_o           (mem_gnt),
        .fill_gnt_o          (fill_gnt),
        .mem_req_valid_o     (mem_req_valid_o),
        .mem_req_o           (mem_req_o),
        .fill_valid_o        (fill_valid_o),
        .fill_o              (fill_o)
    );

endmodule

// ==== bench/mshr_sva.sv ====
// Handshake assertions for the MSHR unit.
// Bound to mshr_unit; checks that stalled ports hold their payload and that
// completions of one block never overlap.

`timescale 1ns/1ps

module mshr_sva #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic                                      clk_i,
    input  logic                                      rst_i,
    input  logic                                      mem_req_valid_i,
    input  logic                                      mem_req_ready_i,
    input  mshr_pkg::mem_req_t                        mem_req_i,
    input  logic                                      fill_valid_i,
    input  logic                                      fill_ready_i,
    input  mshr_pkg::fill_t                           fill_i,
    input  logic [NUM_ENTRIES-1:0]                    cp_flag_i,
    input  mshr_pkg::entry_status_t [NUM_ENTRIES-1:0] status_i
);

    logic dup_cp;

    // Two completion pulses for the same block in one cycle
    always_comb begin
        dup_cp = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            for (int j = i + 1; j < NUM_ENTRIES; j++) begin
                if (cp_flag_i[i] && cp_flag_i[j]
                    && (status_i[i].blk_addr == status_i[j].blk_addr)) begin
                    dup_cp = 1'b1;
                end
            end
        end
    end

    a_mem_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
        else $error("memory request dropped or changed while stalled");

    a_fill_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        fill_valid_i && !fill_ready_i |=> fill_valid_i && $stable(fill_i))
        else $error("fill dropped or changed while stalled");

    a_cp_unique: assert property (@(posedge clk_i) disable iff (rst_i) !dup_cp)
        else $error("two completions for one block in the same cycle");

endmodule

bind mshr_unit mshr_sva #(.NUM_ENTRIES(NUM_ENTRIES)) u_sva (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_i       (mem_req_o),
    .fill_valid_i    (fill_valid_o),
    .fill_ready_i    (fill_ready_i),
    .fill_i          (fill_o),
    .cp_flag_i       (cp_flag),
    .status_i        (status)
);

// ==== bench/mshr_tb.sv ====
// Directed testbench for the MSHR unit.
// A memory model answers block reads and a shadow model predicts every fill.
// Each test is one task that issues misses and waits until its fills drain.

`timescale 1ns/1ps

module mshr_tb;
    import mshr_pkg::*;

    localparam int NUM_ENTRIES = 4;
    localparam int CLK_PERIOD  = 20;
    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 200;

    logic      clk_i;
    logic      rst_i;
    logic      req_valid_i;
    logic      req_ready_o;
    miss_req_t req_i;
    logic      mem_req_valid_o;
    logic      mem_req_ready_i;
    mem_req_t  mem_req_o;
    logic      mem_rsp_valid_i;
    mem_rsp_t  mem_rsp_i;
    logic      fill_valid_o;
    logic      fill_ready_i;
    fill_t     fill_o;

    int       seed          = 25948;
    int       checks        = 0;
    int       mismatches    = 0;
    int       failures      = 0;
    int       mem_req_count = 0;
    int       rsp_gap       = 0;
    string    test_name     = "reset";
    bit       env_on;
    bit       mem_hold;
    bit       mem_reverse;
    bit       fill_hold;
    bit       verdict_done;
    bit       ent_busy[NUM_ENTRIES];
    time      freed_at[NUM_ENTRIES];
    mem_req_t mem_pending[$];
    fill_t    exp_q[$];
    block_t   shadow[addr_t];

    mshr_unit #(.NUM_ENTRIES(NUM_ENTRIES)) uut (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_i           (req_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_i       (mem_rsp_i),
        .fill_valid_o    (fill_valid_o),
        .fill_ready_i    (fill_ready_i),
        .fill_o          (fill_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Budget of 200 cycles per test plus the reset cycles
    initial begin
        #(CLK_PERIOD * (NUM_TESTS * TEST_CYCLES + 8));
        $display("timeout: tests did not finish within %0d cycles",
                 NUM_TESTS * TEST_CYCLES + 8);
        $display("** FAIL **");
        verdict_done = 1'b1;
        $finish;
    end

    // ========================================
    // Reference rules
    // ========================================
    function automatic addr_t blk_of(input addr_t addr);
        return addr & ~addr_t'(7);
    endfunction

    // Memory content is the block address on top and its inverse below
    function automatic block_t mem_rule(input addr_t blk);
        return {blk, ~blk};
    endfunction

    // Byte-wise store of 1 << size bytes starting at the offset
    function automatic block_t apply_store(input block_t old, input block_t data,
                                           input addr_t addr, input size_e size);
        block_t res;
        int     nbytes;
        int     off;
        res    = old;
        nbytes = 1 << int'(size);
        off    = int'(addr[2:0]);
        for (int b = 0; b < nbytes && off + b < 8; b++) begin
            res[(off + b) * 8 +: 8] = data[b * 8 +: 8];
        end
        return res;
    endfunction

    task automatic check_value(input string what, input logic [127:0] exp,
                               input logic [127:0] act);
        checks++;
        if (exp !== act) begin
            mismatches++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic report_error(input string msg);
        failures++;
        $display("error in %s: %s", test_name, msg);
    endtask

    // Shadow update in issue order with one expected fill per request
    task automatic predict(input miss_req_t req);
        fill_t exp;
        addr_t blk;
        bit    found;
        blk = blk_of(req.addr);
        if (!shadow.exists(blk)) begin
            shadow[blk] = mem_rule(blk);
        end
        if (req.cmd == CMD_STORE) begin
            shadow[blk] = apply_store(shadow[blk], req.data, req.addr, req.size);
        end
        exp.cmd  = req.cmd;
        exp.addr = req.addr;
        exp.data = shadow[blk];
        exp.idx  = '0;
        // Lowest idle entry, where one freed at this edge is still busy
        found = 1'b0;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            if (!found && !ent_busy[e] && freed_at[e] != $time) begin
                found   = 1'b1;
                exp.idx = tag_t'(e);
            end
        end
        if (!found) begin
            report_error("request accepted while every entry was busy");
        end else begin
            ent_busy[exp.idx] = 1'b1;
        end
        exp_q.push_back(exp);
    endtask

    // ========================================
    // Memory model and fill collector
    // ========================================
    task automatic serve_memory();
        int pick;
        mem_rsp_valid_i = 1'b0;
        if (rsp_gap > 0) begin
            rsp_gap--;
        end else if (!mem_hold && mem_pending.size() > 0) begin
            pick = 0;
            if (mem_reverse) begin
                for (int i = 1; i < mem_pending.size(); i++) begin
                    if (mem_pending[i].tag > mem_pending[pick].tag) pick = i;
                end
            end else begin
                pick = int'($unsigned($random(seed)) % mem_pending.size());
            end
            mem_rsp_valid_i = 1'b1;
            mem_rsp_i.tag   = mem_pending[pick].tag;
            mem_rsp_i.data  = mem_rule(blk_of(mem_pending[pick].addr));
            mem_pending.delete(pick);
            rsp_gap = $random(seed) & 3;
        end
        // Requests taken now transfer at the next rising edge
        mem_req_ready_i = ($random(seed) & 3) != 0;
        if (mem_req_valid_o && mem_req_ready_i) begin
            if (mem_req_o.addr[2:0] != 3'b000) begin
                report_error("memory request address is not block aligned");
            end
            mem_pending.push_back(mem_req_o);
            mem_req_count++;
        end
    endtask

    task automatic collect_fill();
        int idx;
        idx = -1;
        fill_ready_i = (($random(seed) & 3) != 0) && !fill_hold;
        if (fill_valid_o && fill_ready_i) begin
            // Oldest open miss to the same block
            for (int i = exp_q.size() - 1; i >= 0; i--) begin
                if (blk_of(exp_q[i].addr) == blk_of(fill_o.addr)) idx = i;
            end
            if (idx < 0) begin
                report_error("fill arrived with no open miss to its block");
            end else begin
                check_value("fill cmd", exp_q[idx].cmd, fill_o.cmd);
                check_value("fill addr", exp_q[idx].addr, fill_o.addr);
                check_value("fill data", exp_q[idx].data, fill_o.data);
                check_value("fill entry", exp_q[idx].idx, fill_o.idx);
                // The entry is idle from the next rising edge on
                ent_busy[exp_q[idx].idx] = 1'b0;
                freed_at[exp_q[idx].idx] = $time;
                exp_q.delete(idx);
            end
        end
    endtask

    initial begin
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_i       = '0;
        fill_ready_i    = 1'b0;
        wait (env_on);
        forever begin
            @(negedge clk_i);
            serve_memory();
            collect_fill();
        end
    end

    // ========================================
    // Request helpers
    // ========================================
    task automatic issue(input cmd_e cmd, input addr_t addr, input size_e size,
                         input block_t data);
        miss_req_t req;
        req.cmd     = cmd;
        req.addr    = addr;
        req.size    = size;
        req.data    = data;
        req_valid_i = 1'b1;
        req_i       = req;
        while (!req_ready_o) @(negedge clk_i);
        predict(req);
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk_i);
        @(negedge clk_i);
        shadow.delete();
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic test_single_load();
        int start;
        test_name = "single_load";
        @(negedge clk_i);
        check_value("ready after reset", 1, req_ready_o);
        check_value("mem valid after reset", 0, mem_req_valid_o);
        check_value("fill valid after reset", 0, fill_valid_o);
        start = mem_req_count;
        issue(CMD_LOAD, 32'h0001_1234, SIZE_WORD, '0);
        wait_drain();
        check_value("memory requests", 1, mem_req_count - start);
    endtask

    task automatic test_store_merge();
        size_e  sizes[8] = '{SIZE_BYTE, SIZE_BYTE, SIZE_BYTE, SIZE_HALF,
                             SIZE_HALF, SIZE_WORD, SIZE_WORD, SIZE_DOUBLE};
        int     offs[8]  = '{0, 3, 7, 2, 6, 0, 4, 0};
        block_t data;
        test_name = "store_merge";
        @(negedge clk_i);
        // One block per store so each reads fresh memory
        for (int i = 0; i < 8; i++) begin
            data[63:32] = $random(seed);
            data[31:0]  = $random(seed);
            issue(CMD_STORE, addr_t'(32'h0002_0000 + i * 8 + offs[i]), sizes[i], data);
        end
        wait_drain();
    endtask

    task automatic test_dependent_chain();
        int start;
        test_name = "dependent_chain";
        start     = mem_req_count;
        mem_hold  = 1'b1;
        @(negedge clk_i);
        issue(CMD_LOAD, 32'h0003_0100, SIZE_DOUBLE, '0);
        issue(CMD_STORE, 32'h0003_0102, SIZE_HALF, 64'h0000_0000_0000_beef);
        issue(CMD_STORE, 32'h0003_0104, SIZE_WORD, 64'h0000_0000_cafe_f00d);
        repeat (10) @(negedge clk_i);
        mem_hold = 1'b0;
        wait_drain();
        check_value("memory requests", 1, mem_req_count - start);
    endtask

    task automatic test_out_of_order();
        block_t data;
        test_name = "out_of_order";
        mem_hold  = 1'b1;
        @(negedge clk_i);
        for (int i = 0; i < 4; i++) begin
            data[63:32] = $random(seed);
            data[31:0]  = $random(seed);
            issue((i % 2 == 1) ? CMD_STORE : CMD_LOAD,
                  addr_t'(32'h0004_0004 + i * 32'h40), SIZE_WORD, data);
        end
        while (mem_pending.size() < 4) @(negedge clk_i);
        // Answer the highest tag first
        mem_reverse = 1'b1;
        mem_hold    = 1'b0;
        wait_drain();
        mem_reverse = 1'b0;
    endtask

    task automatic test_full_backpressure();
        fill_t held;
        test_name = "full_backpressure";
        fill_hold = 1'b1;
        @(negedge clk_i);
        for (int i = 0; i < 4; i++) begin
            issue(CMD_LOAD, addr_t'(32'h0005_0000 + i * 8), SIZE_BYTE, '0);
        end
        check_value("ready with four open misses", 0, req_ready_o);
        while (!fill_valid_o) @(negedge clk_i);
        held = fill_o;
        repeat (10) begin
            @(negedge clk_i);
            check_value("fill valid while stalled", 1, fill_valid_o);
            check_value("fill payload while stalled", held, fill_o);
        end
        fill_hold = 1'b0;
        wait_drain();
        check_value("ready after drain", 1, req_ready_o);
    endtask

    initial begin
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i  = 1'b0;
        env_on = 1'b1;

        test_single_load();
        test_store_merge();
        test_dependent_chain();
        test_out_of_order();
        test_full_backpressure();

        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, failures);
        verdict_done = 1'b1;
        if (mismatches == 0 && failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // A run cut short by a failed assertion ends here without a verdict
    final begin
        if (!verdict_done) begin
            $display("** FAIL **");
        end
    end

endmodule

// ==== build.f ====
design/mshr_pkg.sv
design/mshr_alloc.sv
design/mshr_entry.sv
design/mshr_drain.sv
design/mshr_unit.sv
bench/mshr_sva.sv
bench/mshr_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MSHR testbench with Verilator.
# Exit status is nonzero when the build, the run or the testbench fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG='** FAIL **'

if ! verilator --binary --assert -Wno-fatal -f build.f \
        --top-module mshr_tb -Mdir obj_dir -o mshr_sim; then
    echo "run.sh: verilator build failed"
    exit 1
fi

./obj_dir/mshr_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if grep -q -F "$FAIL_MSG" "$LOG"; then
    echo "run.sh: testbench reported failure"
    exit 1
fi

echo "run.sh: simulation passed"
exit 0
